// ==== hdl/cnn_pkg.sv ====
`default_nettype none

package cnn_pkg;

	// datapath sizes
	localparam int PIX_W = 8;
	localparam int WGT_W = 4;
	localparam int N_CH = 4;
	localparam int PATCH = 4;
	localparam int KSIZE = 3;
	// positions (0,0) (0,1) (1,0) (1,1)
	localparam int N_POS = 4;
	localparam int FEAT_W = 8;
	localparam int FEAT_MAX = 127;
	localparam int ACC_DEFAULT = 20;

	// wishbone word addresses
	localparam int ADDR_W = 6;
	localparam logic [ADDR_W-1:0] REG_PIX_BASE = ADDR_W'(0);
	localparam logic [ADDR_W-1:0] REG_WGT_BASE = ADDR_W'(16);
	localparam logic [ADDR_W-1:0] REG_BIAS = ADDR_W'(28);
	localparam logic [ADDR_W-1:0] REG_CMD = ADDR_W'(29);
	localparam logic [ADDR_W-1:0] REG_STATUS = ADDR_W'(30);
	localparam logic [ADDR_W-1:0] REG_FEAT = ADDR_W'(31);
	localparam logic [ADDR_W-1:0] REG_MAX = ADDR_W'(32);

	typedef enum logic [1:0] {
		CMD_NOP = 2'd0,
		CMD_START = 2'd1,
		CMD_CLEAR = 2'd2
	} cmd_e;

	typedef enum logic [2:0] {
		S_IDLE,
		S_WINDOW,
		S_MAC,
		S_QUANT,
		S_POOL,
		S_DONE
	} run_state_e;

endpackage

`default_nettype wire

// ==== hdl/kernel_mac.sv ====
`default_nettype none

module kernel_mac #(
	parameter int ACC_W = cnn_pkg::ACC_DEFAULT
) (
	input  logic                                               clk,
	input  logic                                               mac_en_i,
	input  logic [cnn_pkg::KSIZE*cnn_pkg::KSIZE*cnn_pkg::PIX_W-1:0] win_i,
	input  logic [cnn_pkg::KSIZE*cnn_pkg::KSIZE*cnn_pkg::WGT_W-1:0] taps_i,
	output logic signed [ACC_W-1:0]                            sum_o
);
	import cnn_pkg::*;

	localparam int N_TAP = KSIZE * KSIZE;

	logic signed [ACC_W-1:0] acc;

	// pixels are unsigned, so pad a zero before going signed
	always_comb begin
		acc = '0;
		for (int t = 0; t < N_TAP; t++) begin
			acc = acc + $signed({1'b0, win_i[t*PIX_W +: PIX_W]})
				* $signed(taps_i[t*WGT_W +: WGT_W]);
		end
	end

	always_ff @(posedge clk) begin
		if (mac_en_i) begin
			sum_o <= acc;
		end
	end

endmodule

`default_nettype wire

// ==== hdl/patch_store.sv ====
`default_nettype none

module patch_store (
	input  logic        clk,
	input  logic        rst_n,
	input  logic        pix_we_i,
	input  logic [3:0]  row_sel_i,
	input  logic [31:0] wr_data_i,
	input  logic        win_en_i,
	output logic [cnn_pkg::N_CH*cnn_pkg::N_POS*cnn_pkg::KSIZE*cnn_pkg::KSIZE
		*cnn_pkg::PIX_W-1:0] win_o
);
	import cnn_pkg::*;

	// windows per patch side
	localparam int SIDE = PATCH - KSIZE + 1;
	localparam int N_TAP = KSIZE * KSIZE;

	// row index is channel * PATCH + patch row
	logic [PIX_W-1:0] pix [N_CH*PATCH][PATCH];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int r = 0; r < N_CH * PATCH; r++) begin
				for (int c = 0; c < PATCH; c++) begin
					pix[r][c] <= '0;
				end
			end
		end else if (pix_we_i) begin
			// column 0 sits in the top byte
			for (int c = 0; c < PATCH; c++) begin
				pix[row_sel_i][c] <= wr_data_i[(PATCH - 1 - c) * PIX_W +: PIX_W];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (win_en_i) begin
			for (int ch = 0; ch < N_CH; ch++) begin
				for (int pos = 0; pos < N_POS; pos++) begin
					for (int t = 0; t < N_TAP; t++) begin
						win_o[((ch * N_POS + pos) * N_TAP + t) * PIX_W +: PIX_W] <=
							pix[ch * PATCH + pos / SIDE + t / KSIZE][pos % SIDE + t % KSIZE];
					end
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== hdl/weight_store.sv ====
`default_nettype none

module weight_store (
	input  logic                                 clk,
	input  logic                                 rst_n,
	input  logic                                 wgt_we_i,
	input  logic                                 bias_we_i,
	input  logic [3:0]                           row_sel_i,
	input  logic [31:0]                          wr_data_i,
	output logic [cnn_pkg::N_CH*cnn_pkg::KSIZE*cnn_pkg::KSIZE
		*cnn_pkg::WGT_W-1:0]                     taps_o,
	output logic signed [cnn_pkg::WGT_W-1:0]     bias_o
);
	import cnn_pkg::*;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			taps_o <= '0;
			bias_o <= '0;
		end else begin
			// kernel row index = channel * KSIZE + row, so tap index = row_sel * KSIZE + col
			if (wgt_we_i) begin
				for (int c = 0; c < KSIZE; c++) begin
					taps_o[(row_sel_i * KSIZE + c) * WGT_W +: WGT_W] <=
						wr_data_i[(KSIZE - 1 - c) * WGT_W +: WGT_W];
				end
			end
			if (bias_we_i) begin
				bias_o <= wr_data_i[WGT_W-1:0];
			end
		end
	end

endmodule

`default_nettype wire

// ==== hdl/quant_pool.sv ====
`default_nettype none

module quant_pool #(
	parameter int ACC_W = cnn_pkg::ACC_DEFAULT,
	parameter int OUT_SHIFT = 7,
	parameter int BIAS_SHIFT = 7
) (
	input  logic                                         clk,
	input  logic                                         rst_n,
	input  logic                                         quant_en_i,
	input  logic                                         pool_en_i,
	input  logic [cnn_pkg::N_CH*cnn_pkg::N_POS*ACC_W-1:0] lane_sum_i,
	input  logic signed [cnn_pkg::WGT_W-1:0]             bias_i,
	output logic [cnn_pkg::N_POS*cnn_pkg::FEAT_W-1:0]    feat_o,
	output logic [cnn_pkg::FEAT_W-1:0]                   max_o
);
	import cnn_pkg::*;

	// headroom for four lanes plus bias and rounding
	localparam int BIAS_W = WGT_W + BIAS_SHIFT;
	localparam int SUM_W = (ACC_W > BIAS_W ? ACC_W : BIAS_W) + 3;

	logic signed [SUM_W-1:0] pre [N_POS];
	logic signed [SUM_W-1:0] shifted_q [N_POS];
	logic [FEAT_W-1:0] clamp [N_POS];
	logic [FEAT_W-1:0] pool_max;

	always_comb begin
		for (int p = 0; p < N_POS; p++) begin
			pre[p] = (SUM_W'(bias_i) <<< BIAS_SHIFT) + (SUM_W'(1) <<< (OUT_SHIFT - 1));
			for (int ch = 0; ch < N_CH; ch++) begin
				pre[p] = pre[p] + SUM_W'($signed(lane_sum_i[(ch * N_POS + p) * ACC_W +: ACC_W]));
			end
		end
	end

	always_ff @(posedge clk) begin
		if (quant_en_i) begin
			for (int p = 0; p < N_POS; p++) begin
				shifted_q[p] <= pre[p] >>> OUT_SHIFT;
			end
		end
	end

	always_comb begin
		for (int p = 0; p < N_POS; p++) begin
			if (shifted_q[p] >= FEAT_MAX) begin
				clamp[p] = FEAT_W'(FEAT_MAX);
			end else if (shifted_q[p] < 0) begin
				clamp[p] = '0;
			end else begin
				clamp[p] = shifted_q[p][FEAT_W-1:0];
			end
		end
		pool_max = clamp[0];
		for (int p = 1; p < N_POS; p++) begin
			if (clamp[p] > pool_max) begin
				pool_max = clamp[p];
			end
		end
	end

	// feature 0 in the top byte
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			feat_o <= '0;
			max_o <= '0;
		end else if (pool_en_i) begin
			for (int p = 0; p < N_POS; p++) begin
				feat_o[(N_POS - 1 - p) * FEAT_W +: FEAT_W] <= clamp[p];
			end
			max_o <= pool_max;
		end
	end

	for (genvar p = 0; p < N_POS; p++) begin : g_chk
		a_feat_range: assert property (@(posedge clk) disable iff (!rst_n)
			pool_en_i |=> (feat_o[p*FEAT_W +: FEAT_W] <= FEAT_MAX)
				&& (feat_o[p*FEAT_W +: FEAT_W] <= max_o));
	end

endmodule

`default_nettype wire

// ==== hdl/conv_ctrl.sv ====
`default_nettype none

module conv_ctrl (
	input  logic                                      clk,
	input  logic                                      rst_n,
	input  logic                                      wb_cyc_i,
	input  logic                                      wb_stb_i,
	input  logic                                      wb_we_i,
	input  logic [cnn_pkg::ADDR_W-1:0]                wb_adr_i,
	input  logic [31:0]                               wb_dat_i,
	input  logic [cnn_pkg::N_POS*cnn_pkg::FEAT_W-1:0] feat_i,
	input  logic [cnn_pkg::FEAT_W-1:0]                max_i,
	output logic [31:0]                               wb_dat_o,
	output logic                                      wb_ack_o,
	output logic                                      pix_we_o,
	output logic                                      wgt_we_o,
	output logic                                      bias_we_o,
	output logic [3:0]                                row_sel_o,
	output logic [31:0]                               wr_data_o,
	output logic                                      win_en_o,
	output logic                                      mac_en_o,
	output logic                                      quant_en_o,
	output logic                                      pool_en_o
);
	import cnn_pkg::*;

	localparam logic [ADDR_W-1:0] PIX_END = REG_PIX_BASE + ADDR_W'(N_CH * PATCH);
	localparam logic [ADDR_W-1:0] WGT_END = REG_WGT_BASE + ADDR_W'(N_CH * KSIZE);

	run_state_e state;
	logic done_q;
	logic busy;
	logic req;
	logic wr;
	logic pix_hit;
	logic wgt_hit;
	logic start_cmd;
	logic clear_cmd;
	logic [31:0] rd_data;

	// request seen, ack goes out on the next edge
	assign req = wb_cyc_i && wb_stb_i && !wb_ack_o;
	assign wr = req && wb_we_i;
	assign busy = state inside {S_WINDOW, S_MAC, S_QUANT, S_POOL};

	assign pix_hit = wb_adr_i < PIX_END;
	assign wgt_hit = wb_adr_i >= REG_WGT_BASE && wb_adr_i < WGT_END;
	assign pix_we_o = wr && !busy && pix_hit;
	assign wgt_we_o = wr && !busy && wgt_hit;
	assign bias_we_o = wr && !busy && wb_adr_i == REG_BIAS;
	assign row_sel_o = pix_hit ? 4'(wb_adr_i - REG_PIX_BASE) : 4'(wb_adr_i - REG_WGT_BASE);
	assign wr_data_o = wb_dat_i;

	always_comb begin
		start_cmd = 1'b0;
		clear_cmd = 1'b0;
		if (wr && wb_adr_i == REG_CMD && wb_dat_i[31:2] == '0) begin
			case (cmd_e'(wb_dat_i[1:0]))
				CMD_START: start_cmd = !busy;
				CMD_CLEAR: clear_cmd = 1'b1;
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= S_IDLE;
		end else begin
			case (state)
				S_IDLE, S_DONE: state <= start_cmd ? S_WINDOW : S_IDLE;
				S_WINDOW: state <= S_MAC;
				S_MAC: state <= S_QUANT;
				S_QUANT: state <= S_POOL;
				S_POOL: state <= S_DONE;
				default: state <= S_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			done_q <= 1'b0;
		end else if (start_cmd || clear_cmd) begin
			done_q <= 1'b0;
		end else if (state == S_DONE) begin
			done_q <= 1'b1;
		end
	end

	// one strobe per stage
	assign win_en_o = state == S_WINDOW;
	assign mac_en_o = state == S_MAC;
	assign quant_en_o = state == S_QUANT;
	assign pool_en_o = state == S_POOL;

	always_comb begin
		case (wb_adr_i)
			REG_STATUS: rd_data = {30'b0, done_q, busy};
			REG_FEAT: rd_data = feat_i;
			REG_MAX: rd_data = 32'(max_i);
			default: rd_data = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wb_ack_o <= 1'b0;
		end else begin
			wb_ack_o <= req;
		end
	end

	always_ff @(posedge clk) begin
		if (req) begin
			wb_dat_o <= rd_data;
		end
	end

	a_ack_single: assert property (@(posedge clk) disable iff (!rst_n) wb_ack_o |=> !wb_ack_o);
	a_done_idle: assert property (@(posedge clk) disable iff (!rst_n) done_q |-> !busy);

endmodule

`default_nettype wire

// ==== hdl/conv_top.sv ====
`default_nettype none

module conv_top #(
	parameter int ACC_W = cnn_pkg::ACC_DEFAULT,
	parameter int OUT_SHIFT = 7,
	parameter int BIAS_SHIFT = 7
) (
	input  logic                       clk,
	input  logic                       rst_n,
	input  logic                       wb_cyc_i,
	input  logic                       wb_stb_i,
	input  logic                       wb_we_i,
	input  logic [cnn_pkg::ADDR_W-1:0] wb_adr_i,
	input  logic [31:0]                wb_dat_i,
	output logic [31:0]                wb_dat_o,
	output logic                       wb_ack_o
);
	import cnn_pkg::*;

	localparam int N_TAP = KSIZE * KSIZE;
	localparam int N_LANE = N_CH * N_POS;

	logic pix_we;
	logic wgt_we;
	logic bias_we;
	logic [3:0] row_sel;
	logic [31:0] wr_data;
	logic win_en;
	logic mac_en;
	logic quant_en;
	logic pool_en;
	logic [N_LANE*N_TAP*PIX_W-1:0] win;
	logic [N_CH*N_TAP*WGT_W-1:0] taps;
	logic signed [WGT_W-1:0] bias;
	logic [N_LANE*ACC_W-1:0] lane_sum;
	logic [N_POS*FEAT_W-1:0] feat;
	logic [FEAT_W-1:0] feat_max;

	conv_ctrl u_ctrl (
		.clk(clk), .rst_n(rst_n),
		.wb_cyc_i(wb_cyc_i), .wb_stb_i(wb_stb_i), .wb_we_i(wb_we_i),
		.wb_adr_i(wb_adr_i), .wb_dat_i(wb_dat_i),
		.feat_i(feat), .max_i(feat_max),
		.wb_dat_o(wb_dat_o), .wb_ack_o(wb_ack_o),
		.pix_we_o(pix_we), .wgt_we_o(wgt_we), .bias_we_o(bias_we),
		.row_sel_o(row_sel), .wr_data_o(wr_data),
		.win_en_o(win_en), .mac_en_o(mac_en), .quant_en_o(quant_en), .pool_en_o(pool_en)
	);

	patch_store u_patch (
		.clk(clk), .rst_n(rst_n), .pix_we_i(pix_we), .row_sel_i(row_sel),
		.wr_data_i(wr_data), .win_en_i(win_en), .win_o(win)
	);

	weight_store u_weight (
		.clk(clk), .rst_n(rst_n), .wgt_we_i(wgt_we), .bias_we_i(bias_we),
		.row_sel_i(row_sel), .wr_data_i(wr_data), .taps_o(taps), .bias_o(bias)
	);

	// lane = channel * N_POS + position, kernel taken from the channel
	for (genvar lane = 0; lane < N_LANE; lane++) begin : g_lane
		localparam int CH = lane / N_POS;

		kernel_mac #(.ACC_W(ACC_W)) u_mac (
			.clk(clk),
			.mac_en_i(mac_en),
			.win_i(win[lane*N_TAP*PIX_W +: N_TAP*PIX_W]),
			.taps_i(taps[CH*N_TAP*WGT_W +: N_TAP*WGT_W]),
			.sum_o(lane_sum[lane*ACC_W +: ACC_W])
		);
	end

	quant_pool #(.ACC_W(ACC_W), .OUT_SHIFT(OUT_SHIFT), .BIAS_SHIFT(BIAS_SHIFT)) u_quant (
		.clk(clk), .rst_n(rst_n), .quant_en_i(quant_en), .pool_en_i(pool_en),
		.lane_sum_i(lane_sum), .bias_i(bias), .feat_o(feat), .max_o(feat_max)
	);

endmodule

`default_nettype wire

// ==== include/conv_model.svh ====
`ifndef CONV_MODEL_SVH
`define CONV_MODEL_SVH

// expected clamped feature at one output position
function automatic int model_feature(
	input int pix [cnn_pkg::N_CH][cnn_pkg::PATCH][cnn_pkg::PATCH],
	input int taps [cnn_pkg::N_CH][cnn_pkg::KSIZE][cnn_pkg::KSIZE],
	input int bias,
	input int pos,
	input int out_shift,
	input int bias_shift
);
	int side;
	int acc;
	side = cnn_pkg::PATCH - cnn_pkg::KSIZE + 1;
	acc = (bias <<< bias_shift) + (1 <<< (out_shift - 1));
	for (int ch = 0; ch < cnn_pkg::N_CH; ch++) begin
		for (int r = 0; r < cnn_pkg::KSIZE; r++) begin
			for (int c = 0; c < cnn_pkg::KSIZE; c++) begin
				acc += pix[ch][pos / side + r][pos % side + c] * taps[ch][r][c];
			end
		end
	end
	acc = acc >>> out_shift;
	if (acc >= cnn_pkg::FEAT_MAX)
		return cnn_pkg::FEAT_MAX;
	if (acc < 0)
		return 0;
	return acc;
endfunction

// largest of the pooled features
function automatic int model_max(input int feat [cnn_pkg::N_POS]);
	int m;
	m = feat[0];
	for (int p = 1; p < cnn_pkg::N_POS; p++) begin
		if (feat[p] > m)
			m = feat[p];
	end
	return m;
endfunction

// feature word as read from REG_FEAT, feature 0 in the top byte
function automatic logic [31:0] model_feat_word(input int feat [cnn_pkg::N_POS]);
	logic [31:0] w;
	w = '0;
	for (int p = 0; p < cnn_pkg::N_POS; p++) begin
		w[(cnn_pkg::N_POS - 1 - p) * cnn_pkg::FEAT_W +: cnn_pkg::FEAT_W] = cnn_pkg::FEAT_W'(feat[p]);
	end
	return w;
endfunction

`endif

// ==== testbench/tb_conv.sv ====
`default_nettype none

module tb_conv;
	timeunit 1ns;
	timeprecision 1ps;
	import cnn_pkg::*;

	`include "conv_model.svh"

	localparam int OUT_SHIFT = 7;
	localparam int BIAS_SHIFT = 7;
	localparam int ACK_LIMIT = 16;
	localparam int POLL_LIMIT = 40;
	localparam int N_ROWS = 6;

	typedef enum int {K_RANDOM, K_NEG_BIAS, K_SATURATE, K_BUSY_WRITE} kind_e;

	// kind, bias (random rows draw their own), pixel range
	kind_e row_kind [N_ROWS] = '{K_RANDOM, K_RANDOM, K_NEG_BIAS, K_SATURATE, K_BUSY_WRITE,
		K_RANDOM};
	int row_bias [N_ROWS] = '{0, 0, -8, 0, 0, 0};
	int row_lo [N_ROWS] = '{0, 0, 0, 255, 0, 0};
	int row_hi [N_ROWS] = '{255, 255, 3, 255, 40, 40};

	logic clk;
	logic rst_n;
	logic wb_cyc;
	logic wb_stb;
	logic wb_we;
	logic [ADDR_W-1:0] wb_adr;
	logic [31:0] wb_dat_w;
	logic [31:0] wb_dat_r;
	logic wb_ack;

	int errors;
	int checks;
	int pix [N_CH][PATCH][PATCH];
	int taps [N_CH][KSIZE][KSIZE];
	int bias;
	int feat [N_POS];
	logic [31:0] rd_word;

	conv_top #(.ACC_W(ACC_DEFAULT), .OUT_SHIFT(OUT_SHIFT), .BIAS_SHIFT(BIAS_SHIFT)) uut (
		.clk(clk), .rst_n(rst_n),
		.wb_cyc_i(wb_cyc), .wb_stb_i(wb_stb), .wb_we_i(wb_we),
		.wb_adr_i(wb_adr), .wb_dat_i(wb_dat_w),
		.wb_dat_o(wb_dat_r), .wb_ack_o(wb_ack)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	task automatic check_word(input string what, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERROR %0t: %s read %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic wait_ack(input logic [ADDR_W-1:0] adr);
		int n;
		n = 0;
		while (!wb_ack && n < ACK_LIMIT) begin
			@(negedge clk);
			n++;
		end
		if (!wb_ack) begin
			$display("no ack from the DUT for address %0d within %0d cycles", adr, ACK_LIMIT);
			$display("checks: %0d, errors: %0d", checks, errors + 1);
			$display("Test failed");
			$finish;
		end
	endtask

	// drop the request, ack must be gone one cycle later
	task automatic release_bus();
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		@(negedge clk);
		checks++;
		if (wb_ack) begin
			errors++;
			$display("ERROR %0t: ack high for more than one cycle", $time);
		end
	endtask

	task automatic wb_write(input logic [ADDR_W-1:0] adr, input logic [31:0] data);
		@(negedge clk);
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		wb_we = 1'b1;
		wb_adr = adr;
		wb_dat_w = data;
		wait_ack(adr);
		release_bus();
	endtask

	task automatic wb_read(input logic [ADDR_W-1:0] adr, output logic [31:0] data);
		@(negedge clk);
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		wb_we = 1'b0;
		wb_adr = adr;
		wait_ack(adr);
		data = wb_dat_r;
		release_bus();
	endtask

	task automatic wait_done();
		int n;
		logic [31:0] st;
		n = 0;
		st = '0;
		while (!st[1] && n < POLL_LIMIT) begin
			wb_read(REG_STATUS, st);
			n++;
		end
		if (!st[1]) begin
			$display("done never set within %0d status polls after start", POLL_LIMIT);
			$display("checks: %0d, errors: %0d", checks, errors + 1);
			$display("Test failed");
			$finish;
		end
	endtask

	task automatic make_operands(input int row);
		for (int ch = 0; ch < N_CH; ch++) begin
			for (int r = 0; r < PATCH; r++) begin
				for (int c = 0; c < PATCH; c++) begin
					pix[ch][r][c] = $urandom_range(row_hi[row], row_lo[row]);
				end
			end
			for (int r = 0; r < KSIZE; r++) begin
				for (int c = 0; c < KSIZE; c++) begin
					case (row_kind[row])
						K_NEG_BIAS, K_BUSY_WRITE: taps[ch][r][c] = $urandom_range(7, 0);
						K_SATURATE: taps[ch][r][c] = 7;
						default: taps[ch][r][c] = int'($urandom_range(15, 0)) - 8;
					endcase
				end
			end
		end
		if (row_kind[row] == K_RANDOM)
			bias = int'($urandom_range(15, 0)) - 8;
		else
			bias = row_bias[row];
	endtask

	task automatic load_operands();
		logic [31:0] w;
		for (int ch = 0; ch < N_CH; ch++) begin
			for (int r = 0; r < PATCH; r++) begin
				w = {8'(pix[ch][r][0]), 8'(pix[ch][r][1]), 8'(pix[ch][r][2]), 8'(pix[ch][r][3])};
				wb_write(REG_PIX_BASE + ADDR_W'(ch * PATCH + r), w);
			end
			for (int r = 0; r < KSIZE; r++) begin
				w = {20'b0, 4'(taps[ch][r][0]), 4'(taps[ch][r][1]), 4'(taps[ch][r][2])};
				wb_write(REG_WGT_BASE + ADDR_W'(ch * KSIZE + r), w);
			end
		end
		wb_write(REG_BIAS, {28'b0, 4'(bias)});
	endtask

	initial begin
		rst_n = 1'b0;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		wb_adr = '0;
		wb_dat_w = '0;
		errors = 0;
		checks = 0;
		void'($urandom(32'heb4135a2));
		repeat (2) @(negedge clk);
		rst_n = 1'b1;

		wb_read(REG_STATUS, rd_word);
		check_word("status after reset", rd_word, '0);
		wb_read(REG_FEAT, rd_word);
		check_word("features after reset", rd_word, '0);
		wb_read(REG_MAX, rd_word);
		check_word("max after reset", rd_word, '0);

		for (int row = 0; row < N_ROWS; row++) begin
			make_operands(row);
			load_operands();
			for (int p = 0; p < N_POS; p++) begin
				feat[p] = model_feature(pix, taps, bias, p, OUT_SHIFT, BIAS_SHIFT);
			end
			wb_write(REG_CMD, 32'(CMD_START));
			// lands while busy and must be ignored
			if (row_kind[row] == K_BUSY_WRITE) begin
				wb_write(REG_PIX_BASE, 32'hffffffff);
			end
			wait_done();

			wb_read(REG_FEAT, rd_word);
			check_word($sformatf("features row %0d", row), rd_word, model_feat_word(feat));
			if (row_kind[row] == K_NEG_BIAS)
				check_word("features under negative bias", rd_word, 32'h0);
			if (row_kind[row] == K_SATURATE)
				check_word("saturated features", rd_word, 32'h7f7f7f7f);
			wb_read(REG_MAX, rd_word);
			check_word($sformatf("max row %0d", row), rd_word, 32'(model_max(feat)));

			// a second run on the stored pixels exposes a busy write that got through
			if (row_kind[row] == K_BUSY_WRITE) begin
				wb_write(REG_CMD, 32'(CMD_START));
				wait_done();
				wb_read(REG_FEAT, rd_word);
				check_word("features after busy write", rd_word, model_feat_word(feat));
			end

			wb_read(REG_PIX_BASE + ADDR_W'(row), rd_word);
			check_word("pixel address", rd_word, '0);
			wb_write(REG_CMD, 32'(CMD_CLEAR));
			wb_read(REG_STATUS, rd_word);
			check_word("status after clear", rd_word, '0);
		end

		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+include
hdl/cnn_pkg.sv
hdl/kernel_mac.sv
hdl/patch_store.sv
hdl/weight_store.sv
hdl/quant_pool.sv
hdl/conv_ctrl.sv
hdl/conv_top.sv
testbench/tb_conv.sv

// ==== Bender.yml ====
package:
  name: conv_coproc

sources:
  - files:
      - hdl/cnn_pkg.sv
      - hdl/kernel_mac.sv
      - hdl/patch_store.sv
      - hdl/weight_store.sv
      - hdl/quant_pool.sv
      - hdl/conv_ctrl.sv
      - hdl/conv_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - testbench/tb_conv.sv
